// ==== include/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ========================================
// Core widths
// ========================================

`define RV_XLEN 32
`define RV_REG_AW 5

// Program counter value held by an empty stage register.
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== hw/rv_pkg.sv ====
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Decoded operations.
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LW, OP_SW
    } op_t;

    // ========================================
    // Instruction word views
    // ========================================

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fields_t;

    // Branch offset bits as scattered by the B-type encoding.
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fields_t;

    typedef union packed {
        logic [31:0] raw;
        r_fields_t   r_fields;
        b_fields_t   b_fields;
    } inst_u;

    // ========================================
    // Pipeline structs
    // ========================================

    typedef struct packed {
        logic      valid;
        inst_u     inst;
        word_t     inst_pc;
        op_t       op;
        word_t     immed;
        reg_addr_t reg1_addr;
        word_t     reg1_value;
        reg_addr_t reg2_addr;
        word_t     reg2_value;
        word_t     inst_counter;
    } id_ex_t;

    typedef struct packed {
        logic      write_enable;
        reg_addr_t dest_addr;
        word_t     write_data;
    } reg_writer_t;

    typedef struct packed {
        logic  jump_inst;
        logic  do_jump;
        word_t dest_addr;
    } jump_t;

    typedef struct packed {
        logic  valid;
        inst_u inst;
        word_t inst_pc;
        op_t   op;
        word_t alu_result;
        word_t write_mem_data;
        jump_t jump;
        word_t inst_counter;
    } ex_mem_t;

endpackage

`default_nettype wire

// ==== hw/operand_forward.sv ====
`default_nettype none

module operand_forward (
    input  rv_pkg::id_ex_t      id_ex,
    input  rv_pkg::reg_writer_t forward1,
    input  rv_pkg::reg_writer_t forward2,
    output rv_pkg::word_t       reg1,
    output rv_pkg::word_t       reg2
);
    import rv_pkg::*;

    // Nearer stage first, then the older one, then the register file value.
    function automatic word_t pick(
        input reg_addr_t   addr,
        input word_t       value,
        input reg_writer_t near,
        input reg_writer_t far
    );
        word_t sel;
        if (near.write_enable && near.dest_addr != '0 && near.dest_addr == addr) begin
            sel = near.write_data;
        end else if (far.write_enable && far.dest_addr != '0 && far.dest_addr == addr) begin
            sel = far.write_data;
        end else begin
            sel = value;
        end
        return sel;
    endfunction

    always_comb begin
        reg1 = pick(id_ex.reg1_addr, id_ex.reg1_value, forward1, forward2);
        reg2 = pick(id_ex.reg2_addr, id_ex.reg2_value, forward1, forward2);
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

module alu (
    input  rv_pkg::op_t   op,
    input  rv_pkg::word_t reg1,
    input  rv_pkg::word_t reg2,
    input  rv_pkg::word_t immed,
    input  rv_pkg::word_t pc,
    output rv_pkg::word_t result,
    output logic          writes_reg
);
    import rv_pkg::*;

    word_t      opb;
    logic [4:0] shamt;
    logic       use_imm;

    // ========================================
    // Operand selection
    // ========================================

    always_comb begin
        case (op)
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
            OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
            OP_LW, OP_SW: use_imm = 1'b1;
            default:      use_imm = 1'b0;
        endcase
        opb   = use_imm ? immed : reg2;
        shamt = opb[4:0];
    end

    // ========================================
    // Result
    // ========================================

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI:   result = reg1 + opb;
            OP_SUB:            result = reg1 - opb;
            OP_AND, OP_ANDI:   result = reg1 & opb;
            OP_OR, OP_ORI:     result = reg1 | opb;
            OP_XOR, OP_XORI:   result = reg1 ^ opb;
            OP_SLL, OP_SLLI:   result = reg1 << shamt;
            OP_SRL, OP_SRLI:   result = reg1 >> shamt;
            OP_SRA, OP_SRAI:   result = word_t'($signed(reg1) >>> shamt);
            OP_SLT, OP_SLTI:   result = word_t'($signed(reg1) < $signed(opb));
            OP_SLTU, OP_SLTIU: result = word_t'(reg1 < opb);
            OP_LUI:            result = immed;
            OP_AUIPC:          result = pc + immed;
            // Link value.
            OP_JAL, OP_JALR:   result = pc + word_t'(4);
            // Effective address.
            OP_LW, OP_SW:      result = reg1 + opb;
            default:           result = '0;
        endcase
    end

    always_comb begin
        case (op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
            OP_SW:   writes_reg = 1'b0;
            default: writes_reg = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`default_nettype none

`include "rv_macros.svh"

module branch_unit (
    input  rv_pkg::op_t   op,
    input  rv_pkg::inst_u inst,
    input  rv_pkg::word_t reg1,
    input  rv_pkg::word_t reg2,
    input  rv_pkg::word_t immed,
    input  rv_pkg::word_t pc,
    output rv_pkg::jump_t jump
);
    import rv_pkg::*;

    word_t br_offset;
    word_t jalr_sum;
    logic  eq;
    logic  lt_s;
    logic  lt_u;

    // Offset rebuilt from the B-type bit positions.
    always_comb begin
        br_offset = {{(`RV_XLEN-12){inst.b_fields.imm12}},
                     inst.b_fields.imm11,
                     inst.b_fields.imm10_5,
                     inst.b_fields.imm4_1,
                     1'b0};
        jalr_sum  = reg1 + immed;
        eq        = reg1 == reg2;
        lt_s      = $signed(reg1) < $signed(reg2);
        lt_u      = reg1 < reg2;
    end

    always_comb begin
        jump.jump_inst = 1'b1;
        jump.do_jump   = 1'b0;
        jump.dest_addr = pc + br_offset;
        case (op)
            OP_BEQ:  jump.do_jump = eq;
            OP_BNE:  jump.do_jump = !eq;
            OP_BLT:  jump.do_jump = lt_s;
            OP_BGE:  jump.do_jump = !lt_s;
            OP_BLTU: jump.do_jump = lt_u;
            OP_BGEU: jump.do_jump = !lt_u;
            OP_JAL: begin
                jump.do_jump   = 1'b1;
                jump.dest_addr = pc + immed;
            end
            OP_JALR: begin
                jump.do_jump   = 1'b1;
                jump.dest_addr = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            end
            default: jump.jump_inst = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/ex_mem_reg.sv ====
`default_nettype none

`include "rv_macros.svh"

module ex_mem_reg (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  rv_pkg::id_ex_t  id_ex,
    input  rv_pkg::word_t   result,
    input  rv_pkg::word_t   store_data,
    input  rv_pkg::jump_t   jump,
    output rv_pkg::ex_mem_t ex_mem
);
    import rv_pkg::*;

    ex_mem_t next;

    always_comb begin
        next.valid          = id_ex.valid;
        next.inst           = id_ex.inst;
        next.inst_pc        = id_ex.inst_pc;
        next.op             = id_ex.op;
        next.alu_result     = result;
        next.write_mem_data = store_data;
        next.jump           = jump;
        // A bubble never redirects fetch.
        next.jump.do_jump   = jump.do_jump & id_ex.valid;
        next.inst_counter   = id_ex.inst_counter;
    end

    // ========================================
    // Stage register
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid          <= 1'b0;
            ex_mem.inst_pc        <= `RV_RESET_PC;
            ex_mem.jump.jump_inst <= 1'b0;
            ex_mem.jump.do_jump   <= 1'b0;
        end else if (!stall) begin
            ex_mem <= next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  rv_pkg::id_ex_t      id_ex,
    input  rv_pkg::reg_writer_t forward1,
    input  rv_pkg::reg_writer_t forward2,
    output rv_pkg::reg_writer_t forward,
    output rv_pkg::ex_mem_t     ex_mem
);
    import rv_pkg::*;

    word_t reg1;
    word_t reg2;
    word_t alu_result;
    logic  writes_reg;
    jump_t jump;

    operand_forward u_fwd (
        .id_ex    (id_ex),
        .forward1 (forward1),
        .forward2 (forward2),
        .reg1     (reg1),
        .reg2     (reg2)
    );

    alu u_alu (
        .op         (id_ex.op),
        .reg1       (reg1),
        .reg2       (reg2),
        .immed      (id_ex.immed),
        .pc         (id_ex.inst_pc),
        .result     (alu_result),
        .writes_reg (writes_reg)
    );

    branch_unit u_branch (
        .op    (id_ex.op),
        .inst  (id_ex.inst),
        .reg1  (reg1),
        .reg2  (reg2),
        .immed (id_ex.immed),
        .pc    (id_ex.inst_pc),
        .jump  (jump)
    );

    // Store data is the forwarded rs2.
    ex_mem_reg u_ex_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .id_ex      (id_ex),
        .result     (alu_result),
        .store_data (reg2),
        .jump       (jump),
        .ex_mem     (ex_mem)
    );

    // Unregistered bypass of this stage's result; x0 is never announced.
    always_comb begin
        forward.dest_addr    = id_ex.inst.r_fields.rd;
        forward.write_data   = alu_result;
        forward.write_enable = id_ex.valid & writes_reg & (id_ex.inst.r_fields.rd != '0);
    end

endmodule

`default_nettype wire

// ==== verif/execute_sva.sv ====
`default_nettype none

module execute_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                stall,
    input rv_pkg::reg_writer_t forward,
    input rv_pkg::ex_mem_t     ex_mem
);

    // Reset empties the stage register.
    a_reset_clears: assert property (@(posedge clk)
        !rst_n |=> !ex_mem.valid && !ex_mem.jump.do_jump)
        else $error("ex_mem valid or do_jump set after reset edge");

    a_stall_holds: assert property (@(posedge clk)
        rst_n && stall |=> $stable(ex_mem))
        else $error("ex_mem changed while stalled");

    // x0 is never a bypass destination.
    a_no_x0_forward: assert property (@(posedge clk)
        forward.write_enable |-> forward.dest_addr != '0)
        else $error("forward announces a write to x0");

endmodule

bind execute_stage execute_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall   (stall),
    .forward (forward),
    .ex_mem  (ex_mem)
);

`default_nettype wire

// ==== verif/execute_tb.sv ====
`default_nettype none

module execute_tb;
    import rv_pkg::*;

    localparam int          PERIOD = 40;
    localparam reg_addr_t   RD     = 5'd7;
    localparam word_t       PC     = 32'h100;
    localparam reg_writer_t NF     = '0;
    localparam jump_t       NJ     = '0;

    typedef struct packed {
        op_t         op;
        logic        valid;
        reg_addr_t   a1;
        word_t       v1;
        reg_addr_t   a2;
        word_t       v2;
        word_t       imm;
        reg_writer_t f1;
        reg_writer_t f2;
        word_t       res;
        word_t       st;
        jump_t       j;
        logic        we;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        stall;
    id_ex_t      id_ex;
    reg_writer_t forward1;
    reg_writer_t forward2;
    reg_writer_t forward;
    ex_mem_t     ex_mem;

    row_t        rows[$];
    string       names[$];
    logic [15:0] lfsr_state;
    int          num_rows;

    execute_stage UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .id_ex    (id_ex),
        .forward1 (forward1),
        .forward2 (forward2),
        .forward  (forward),
        .ex_mem   (ex_mem)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ========================================
    // Stimulus helpers
    // ========================================

    function automatic reg_writer_t fw(input logic we, input reg_addr_t addr, input word_t data);
        reg_writer_t w;
        w.write_enable = we;
        w.dest_addr    = addr;
        w.write_data   = data;
        return w;
    endfunction

    function automatic jump_t jmp(input logic ji, input logic dj, input word_t dest);
        jump_t j;
        j.jump_inst = ji;
        j.do_jump   = dj;
        j.dest_addr = dest;
        return j;
    endfunction

    // Taps 16, 14, 13, 11.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    // Borrow out of a 33-bit subtraction; signed order flips both sign bits first.
    function automatic word_t less_than(input word_t a, input word_t b, input logic is_signed);
        logic [32:0] diff;
        word_t       flip;
        flip = is_signed ? 32'h8000_0000 : 32'h0;
        diff = {1'b0, a ^ flip} - {1'b0, b ^ flip};
        return word_t'(diff[32]);
    endfunction

    // Branches carry their offset in the B-type bit positions.
    function automatic inst_u make_inst(input op_t op, input word_t imm);
        inst_u u;
        u.raw = '0;
        if (op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}) begin
            u.b_fields.imm12   = imm[12];
            u.b_fields.imm11   = imm[11];
            u.b_fields.imm10_5 = imm[10:5];
            u.b_fields.imm4_1  = imm[4:1];
        end else begin
            u.r_fields.rd = RD;
        end
        return u;
    endfunction

    function automatic id_ex_t make_id_ex(input row_t r, input int idx);
        id_ex_t d;
        d              = '0;
        d.valid        = r.valid;
        d.inst         = make_inst(r.op, r.imm);
        d.inst_pc      = PC;
        d.op           = r.op;
        d.immed        = r.imm;
        d.reg1_addr    = r.a1;
        d.reg1_value   = r.v1;
        d.reg2_addr    = r.a2;
        d.reg2_value   = r.v2;
        d.inst_counter = word_t'(idx + 1);
        return d;
    endfunction

    task automatic add_row(input string name, input op_t op, input word_t v1, input word_t v2,
                           input word_t imm, input reg_writer_t f1, input reg_writer_t f2,
                           input word_t res, input word_t st, input jump_t j, input logic we);
        row_t r;
        r.op    = op;
        r.valid = 1'b1;
        r.a1    = 5'd1;
        r.v1    = v1;
        r.a2    = 5'd2;
        r.v2    = v2;
        r.imm   = imm;
        r.f1    = f1;
        r.f2    = f2;
        r.res   = res;
        r.st    = st;
        r.j     = j;
        r.we    = we;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // ========================================
    // Checks
    // ========================================

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    // Target only matters for jump instructions.
    task automatic check_jump(input string name, input jump_t exp, input jump_t act);
        if (act.jump_inst !== exp.jump_inst || act.do_jump !== exp.do_jump ||
            (exp.jump_inst && act.dest_addr !== exp.dest_addr)) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_writer(input string name, input reg_writer_t exp, input reg_writer_t act);
        if (act.write_enable !== exp.write_enable ||
            (exp.write_enable && (act.dest_addr !== exp.dest_addr ||
                                  act.write_data !== exp.write_data))) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_row_result(input int idx, input string tag);
        row_t  r;
        inst_u exp_inst;
        r        = rows[idx];
        exp_inst = make_inst(r.op, r.imm);
        check_word({tag, " valid"}, word_t'(r.valid), word_t'(ex_mem.valid));
        check_word({tag, " result"}, r.res, ex_mem.alu_result);
        check_word({tag, " store"}, r.st, ex_mem.write_mem_data);
        check_jump({tag, " jump"}, r.j, ex_mem.jump);
        check_word({tag, " pc"}, PC, ex_mem.inst_pc);
        check_word({tag, " op"}, word_t'(r.op), word_t'(ex_mem.op));
        check_word({tag, " inst"}, exp_inst.raw, ex_mem.inst.raw);
        check_word({tag, " counter"}, word_t'(idx + 1), ex_mem.inst_counter);
    endtask

    initial begin
        wait (num_rows > 0);
        #((num_rows + 10) * PERIOD);
        $display("Watchdog expired: the row sequence did not complete in time");
        stop_run();
    end

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        word_t a;
        word_t b;
        clk        = 1'b0;
        rst_n     <= 1'b0;
        stall     <= 1'b0;
        id_ex     <= '0;
        forward1  <= '0;
        forward2  <= '0;
        lfsr_state = 16'd3961;

        add_row("add", OP_ADD, 5, 7, 0, NF, NF, 12, 7, NJ, 1'b1);
        add_row("sub", OP_SUB, 5, 7, 0, NF, NF, 'hffff_fffe, 7, NJ, 1'b1);
        add_row("andi", OP_ANDI, 'hff0f, 0, 'h0ff0, NF, NF, 'h0f00, 0, NJ, 1'b1);
        add_row("or", OP_OR, 'hf0, 'h0f, 0, NF, NF, 'hff, 'h0f, NJ, 1'b1);
        add_row("xori", OP_XORI, 'haaaa, 0, 'hffff, NF, NF, 'h5555, 0, NJ, 1'b1);
        add_row("sll", OP_SLL, 1, 35, 0, NF, NF, 8, 35, NJ, 1'b1);
        add_row("srli", OP_SRLI, 'h8000_0000, 0, 4, NF, NF, 'h0800_0000, 0, NJ, 1'b1);
        add_row("sra", OP_SRA, 'h8000_0000, 4, 0, NF, NF, 'hf800_0000, 4, NJ, 1'b1);
        add_row("srai", OP_SRAI, 'h8000_0010, 0, 36, NF, NF, 'hf800_0001, 0, NJ, 1'b1);
        add_row("slt", OP_SLT, -1, 1, 0, NF, NF, 1, 1, NJ, 1'b1);
        add_row("sltu", OP_SLTU, -1, 1, 0, NF, NF, 0, 1, NJ, 1'b1);
        add_row("slti", OP_SLTI, 5, 0, -3, NF, NF, 0, 0, NJ, 1'b1);
        add_row("sltiu", OP_SLTIU, 5, 0, -3, NF, NF, 1, 0, NJ, 1'b1);
        add_row("lui", OP_LUI, 0, 0, 'h1234_5000, NF, NF, 'h1234_5000, 0, NJ, 1'b1);
        add_row("auipc", OP_AUIPC, 0, 0, 'h1000, NF, NF, 'h1100, 0, NJ, 1'b1);
        add_row("lw", OP_LW, 'h200, 0, 8, NF, NF, 'h208, 0, NJ, 1'b1);
        add_row("sw", OP_SW, 'h200, 'hdead_beef, -4, NF, NF, 'h1fc, 'hdead_beef, NJ, 1'b0);
        add_row("fwd1 wins", OP_ADD, 1, 2, 0, fw(1'b1, 5'd1, 100), fw(1'b1, 5'd1, 200),
                102, 2, NJ, 1'b1);
        add_row("fwd2 rs2", OP_ADD, 1, 2, 0, fw(1'b1, 5'd3, 9), fw(1'b1, 5'd2, 50),
                51, 50, NJ, 1'b1);
        add_row("fwd x0", OP_ADD, 0, 2, 0, fw(1'b1, 5'd0, 99), NF, 2, 2, NJ, 1'b1);
        rows[rows.size() - 1].a1 = 5'd0;
        add_row("fwd off", OP_ADD, 1, 2, 0, fw(1'b0, 5'd1, 77), NF, 3, 2, NJ, 1'b1);
        add_row("sw fwd", OP_SW, 'h200, 1, 0, fw(1'b1, 5'd2, 'h55), fw(1'b1, 5'd1, 'h300),
                'h300, 'h55, NJ, 1'b0);
        add_row("beq taken", OP_BEQ, 5, 5, 16, NF, NF, 0, 5, jmp(1'b1, 1'b1, 'h110), 1'b0);
        add_row("bne not", OP_BNE, 5, 5, 16, NF, NF, 0, 5, jmp(1'b1, 1'b0, 'h110), 1'b0);
        add_row("blt taken", OP_BLT, -1, 1, -8, NF, NF, 0, 1, jmp(1'b1, 1'b1, 'hf8), 1'b0);
        add_row("bge not", OP_BGE, -1, 1, -8, NF, NF, 0, 1, jmp(1'b1, 1'b0, 'hf8), 1'b0);
        add_row("bltu not", OP_BLTU, -1, 1, 'h800, NF, NF, 0, 1, jmp(1'b1, 1'b0, 'h900), 1'b0);
        add_row("bgeu taken", OP_BGEU, -1, 1, 'h800, NF, NF, 0, 1, jmp(1'b1, 1'b1, 'h900), 1'b0);
        add_row("jal", OP_JAL, 0, 0, 'h40, NF, NF, 'h104, 0, jmp(1'b1, 1'b1, 'h140), 1'b1);
        add_row("jalr", OP_JALR, 'h301, 0, 'h10, NF, NF, 'h104, 0, jmp(1'b1, 1'b1, 'h310), 1'b1);
        // An invalid jump neither redirects nor writes back.
        add_row("bubble", OP_JAL, 0, 0, 'h40, NF, NF, 'h104, 0, jmp(1'b1, 1'b0, 'h140), 1'b1);
        rows[rows.size() - 1].valid = 1'b0;

        for (int i = 0; i < 32; i++) begin
            a = rand_word();
            b = rand_word();
            case (i % 4)
                0: add_row("rand add", OP_ADD, a, b, 0, NF, NF, a + b, b, NJ, 1'b1);
                1: add_row("rand xor", OP_XOR, a, b, 0, NF, NF, a ^ b, b, NJ, 1'b1);
                2: add_row("rand slt", OP_SLT, a, b, 0, NF, NF,
                           less_than(a, b, 1'b1), b, NJ, 1'b1);
                default: add_row("rand sltu", OP_SLTU, a, b, 0, NF, NF,
                                 less_than(a, b, 1'b0), b, NJ, 1'b1);
            endcase
        end
        num_rows = rows.size();

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("reset valid", 0, word_t'(ex_mem.valid));
        check_word("reset do_jump", 0, word_t'(ex_mem.jump.do_jump));

        // One row per cycle, ex_mem of the previous row checked alongside.
        for (int i = 0; i < num_rows; i++) begin
            @(posedge clk);
            id_ex    <= make_id_ex(rows[i], i);
            forward1 <= rows[i].f1;
            forward2 <= rows[i].f2;
            @(negedge clk);
            check_writer({names[i], " forward"},
                         fw(rows[i].valid & rows[i].we, RD, rows[i].res), forward);
            if (i > 0) begin
                check_row_result(i - 1, names[i - 1]);
            end
        end

        @(posedge clk);
        stall <= 1'b1;
        id_ex <= make_id_ex(rows[0], 0);
        @(negedge clk);
        check_row_result(num_rows - 1, names[num_rows - 1]);
        @(posedge clk);
        id_ex <= make_id_ex(rows[1], 1);
        @(negedge clk);
        check_row_result(num_rows - 1, "stall hold");
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        check_row_result(num_rows - 1, "stall second cycle");
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hw/rv_pkg.sv
hw/operand_forward.sv
hw/alu.sv
hw/branch_unit.sv
hw/ex_mem_reg.sv
hw/execute_stage.sv
verif/execute_sva.sv
verif/execute_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= execute_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
